// File: hw/lsu_pkg.sv
// Load/store unit shared definitions
// Data width, DCCM region, store buffer sizing and the packet types
// passed between the pipeline stages

package lsu_pkg;

   //******************************
   // Widths and region limits
   localparam int              XLEN           = 32;
   localparam logic [XLEN-1:0] DCCM_BASE      = 32'hF004_0000; // Aligned to the DCCM size
   localparam int              DCCM_BYTES     = 1024;
   localparam int              DCCM_WORD_BITS = 8;             // 256 words of 4 bytes

   // Store buffer sizing
   localparam int              SB_DEPTH       = 4;
   localparam int              SB_PTR_BITS    = 2;

   // Access size encoding
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   //******************************
   // Request from the issuing stage
   typedef struct packed {
      logic               valid;
      logic               load;
      logic               store;
      access_size_e       size;
      logic               unsign;     // Zero-extend load data
      logic [XLEN-1:0]    rs1;        // Base register
      logic [11:0]        offset;     // Signed immediate
      logic [XLEN-1:0]    store_data;
   } lsu_req_t;

   // Payload carried DC1 to DC3
   typedef struct packed {
      logic               valid;
      logic               load;
      logic               store;
      access_size_e       size;
      logic               unsign;
      logic [XLEN-1:0]    addr;       // Effective address
      logic [XLEN-1:0]    store_data;
      logic               in_dccm;
      logic               misaligned;
   } lsu_stage_t;

   // One store buffer entry, data already in byte lanes
   typedef struct packed {
      logic                      valid;
      logic [DCCM_WORD_BITS-1:0] word;
      logic [3:0]                byteen;
      logic [XLEN-1:0]           data;
   } sb_entry_t;

   // Exception info raised in DC3
   typedef struct packed {
      logic               valid;
      logic               store;
      logic               misaligned;
      logic               access_fault;
      logic [XLEN-1:0]    addr;
   } lsu_error_pkt_t;

   typedef logic [1:0] credit_cnt_t;  // Credits back in one cycle, 0 to 2

endpackage

// File: hw/lsu_addr_ctl.sv
`timescale 1ns/1ps
// Load/store address control
// DC1 forms the effective address and decodes region and alignment,
// DC2 and DC3 carry the payload, DC3 builds the error packet

module lsu_addr_ctl (
   input  logic                    clk,
   input  logic                    rst,
   input  lsu_pkg::lsu_req_t       lsu_req,
   output lsu_pkg::lsu_stage_t     dc2,
   output lsu_pkg::lsu_stage_t     dc3,
   output lsu_pkg::lsu_error_pkt_t lsu_error_pkt
);

   lsu_pkg::lsu_req_t         dc1_req;       // Request held in DC1
   lsu_pkg::lsu_stage_t       dc1;           // Decoded DC1 payload
   logic [lsu_pkg::XLEN-1:0]  offset_ext;    // Sign-extended immediate
   logic [lsu_pkg::XLEN-1:0]  addr_dc1;
   logic [lsu_pkg::XLEN-1:0]  dccm_offset;   // Distance from DCCM base

   //******************************
   // DC1 request register
   always_ff @(posedge clk) begin
      if (rst) begin
         dc1_req.valid <= 1'b0;
      end else begin
         dc1_req <= lsu_req;
      end
   end

   // Effective address
   assign offset_ext  = {{(lsu_pkg::XLEN-12){dc1_req.offset[11]}}, dc1_req.offset};
   assign addr_dc1    = dc1_req.rs1 + offset_ext;
   assign dccm_offset = addr_dc1 - lsu_pkg::DCCM_BASE;  // Wraps high for addresses below base

   // Region and alignment decode
   always_comb begin
      dc1.valid      = dc1_req.valid;
      dc1.load       = dc1_req.load;
      dc1.store      = dc1_req.store;
      dc1.size       = dc1_req.size;
      dc1.unsign     = dc1_req.unsign;
      dc1.addr       = addr_dc1;
      dc1.store_data = dc1_req.store_data;
      dc1.in_dccm    = (dccm_offset < lsu_pkg::DCCM_BYTES);
      case (dc1_req.size)
         lsu_pkg::SIZE_HALF: dc1.misaligned = addr_dc1[0];     // Odd half
         lsu_pkg::SIZE_WORD: dc1.misaligned = |addr_dc1[1:0];
         default:            dc1.misaligned = 1'b0;            // Bytes always aligned
      endcase
   end

   //******************************
   // DC2 and DC3 stage registers
   always_ff @(posedge clk) begin
      if (rst) begin
         dc2.valid <= 1'b0;
      end else begin
         dc2 <= dc1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dc3.valid <= 1'b0;
      end else begin
         dc3 <= dc2;
      end
   end

   // DC3 error packet
   // Misalignment is reported ahead of an access fault
   always_comb begin
      lsu_error_pkt.valid        = dc3.valid & (dc3.misaligned | ~dc3.in_dccm);
      lsu_error_pkt.store        = dc3.valid & dc3.store;
      lsu_error_pkt.misaligned   = dc3.valid & dc3.misaligned;
      lsu_error_pkt.access_fault = dc3.valid & ~dc3.misaligned & ~dc3.in_dccm;
      lsu_error_pkt.addr         = dc3.addr;
   end

   // Issuing stage never sends an access that is both load and store
   a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
      lsu_req.valid |-> !(lsu_req.load && lsu_req.store));

endmodule

// File: hw/lsu_stbuf.sv
`timescale 1ns/1ps
// Load/store unit store buffer
// Four-entry circular buffer of good DC3 stores, drains oldest first
// into the DCCM, forwards bytes to DC3 loads and returns store credits

module lsu_stbuf (
   input  logic                     clk,
   input  logic                     rst,
   input  lsu_pkg::lsu_stage_t      dc3,
   output lsu_pkg::sb_entry_t       drain,
   output logic [lsu_pkg::XLEN-1:0] fwd_data,
   output logic [3:0]               fwd_byteen,
   output lsu_pkg::credit_cnt_t     credit_return,
   output logic                     sb_empty
);

   lsu_pkg::sb_entry_t                  sb_q [lsu_pkg::SB_DEPTH];
   logic [lsu_pkg::SB_PTR_BITS-1:0]     wr_ptr;      // Next free slot
   logic [lsu_pkg::SB_PTR_BITS-1:0]     rd_ptr;      // Oldest entry
   logic [lsu_pkg::SB_PTR_BITS:0]       count;
   logic                                store_dc3;
   logic                                alloc;
   logic                                drop;
   logic                                drain_vld;
   logic [lsu_pkg::DCCM_WORD_BITS-1:0]  word_dc3;
   logic [3:0]                          byteen_dc3;
   logic [lsu_pkg::XLEN-1:0]            data_dc3;

   //******************************
   // DC3 store qualification
   assign store_dc3 = dc3.valid & dc3.store;
   assign alloc     = store_dc3 & dc3.in_dccm & ~dc3.misaligned;
   assign drop      = store_dc3 & ~(dc3.in_dccm & ~dc3.misaligned);  // Errored, credit back now

   // Word index and byte lanes of the DC3 access
   assign word_dc3 = dc3.addr[lsu_pkg::DCCM_WORD_BITS+1:2];
   assign data_dc3 = dc3.store_data << {dc3.addr[1:0], 3'b000};

   always_comb begin
      case (dc3.size)
         lsu_pkg::SIZE_BYTE: byteen_dc3 = 4'b0001 << dc3.addr[1:0];
         lsu_pkg::SIZE_HALF: byteen_dc3 = 4'b0011 << dc3.addr[1:0];
         default:            byteen_dc3 = 4'b1111;
      endcase
   end

   // Oldest entry goes to the DCCM every cycle it is valid
   assign drain     = sb_q[rd_ptr];
   assign drain_vld = sb_q[rd_ptr].valid;
   assign sb_empty  = (count == '0);

   //******************************
   // Pointers, count and entry storage
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         for (int i = 0; i < lsu_pkg::SB_DEPTH; i++) begin
            sb_q[i].valid <= 1'b0;
         end
      end else begin
         if (drain_vld) begin
            sb_q[rd_ptr].valid <= 1'b0;
            rd_ptr             <= rd_ptr + 1'b1;
         end
         if (alloc) begin   // Written after the drain clear so a reused slot stays valid
            sb_q[wr_ptr] <= '{valid: 1'b1, word: word_dc3, byteen: byteen_dc3, data: data_dc3};
            wr_ptr       <= wr_ptr + 1'b1;
         end
         case ({alloc, drain_vld})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // Both or neither
         endcase
      end
   end

   //******************************
   // Forwarding to the DC3 word
   // Walk oldest to youngest so the youngest byte lands last
   always_comb begin
      logic [lsu_pkg::SB_PTR_BITS-1:0] idx;
      fwd_data   = '0;
      fwd_byteen = '0;
      for (int i = 0; i < lsu_pkg::SB_DEPTH; i++) begin
         idx = rd_ptr + i[lsu_pkg::SB_PTR_BITS-1:0];
         if (sb_q[idx].valid && (sb_q[idx].word == word_dc3)) begin
            for (int b = 0; b < 4; b++) begin
               if (sb_q[idx].byteen[b]) begin
                  fwd_data[8*b +: 8] = sb_q[idx].data[8*b +: 8];
                  fwd_byteen[b]      = 1'b1;
               end
            end
         end
      end
   end

   // One credit per drained entry plus one per dropped store
   assign credit_return = {1'b0, drain_vld} + {1'b0, drop};

   // A store that reaches DC3 with the buffer full means credits were overspent
   a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
      alloc |-> (count < lsu_pkg::SB_DEPTH));

   a_count_bound: assert property (@(posedge clk) disable iff (rst)
      count <= lsu_pkg::SB_DEPTH);

endmodule

// File: hw/lsu_dccm_ctl.sv
`timescale 1ns/1ps
// DCCM control
// Holds the data memory, applies store buffer drains, and builds the
// DC3 load result from the DCCM word merged with forwarded bytes

module lsu_dccm_ctl (
   input  logic                     clk,
   input  lsu_pkg::lsu_stage_t      dc2,
   input  lsu_pkg::lsu_stage_t      dc3,
   input  lsu_pkg::sb_entry_t       drain,
   input  logic [lsu_pkg::XLEN-1:0] fwd_data,
   input  logic [3:0]               fwd_byteen,
   output logic                     lsu_result_valid,
   output logic [lsu_pkg::XLEN-1:0] lsu_result
);

   // DCCM array, cleared at power-up
   logic [lsu_pkg::XLEN-1:0] dccm_mem [lsu_pkg::DCCM_BYTES/4] = '{default: '0};

   logic [lsu_pkg::DCCM_WORD_BITS-1:0] rd_word_dc3;   // Word index captured in DC2
   logic [lsu_pkg::XLEN-1:0]           rd_data_dc3;
   logic [lsu_pkg::XLEN-1:0]           merged_dc3;
   logic [lsu_pkg::XLEN-1:0]           shifted_dc3;

   //******************************
   // Drain write, byte enables only
   always_ff @(posedge clk) begin
      if (drain.valid) begin
         for (int b = 0; b < 4; b++) begin
            if (drain.byteen[b]) begin
               dccm_mem[drain.word][8*b +: 8] <= drain.data[8*b +: 8];
            end
         end
      end
   end

   // DC2 read address
   always_ff @(posedge clk) begin
      rd_word_dc3 <= dc2.addr[lsu_pkg::DCCM_WORD_BITS+1:2];
   end

   //******************************
   // DC3 read and forward merge
   assign rd_data_dc3 = dccm_mem[rd_word_dc3];    // Async read, pre-edge contents

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged_dc3[8*b +: 8] = fwd_byteen[b] ? fwd_data[8*b +: 8]
                                              : rd_data_dc3[8*b +: 8];
      end
   end

   // Move the addressed bytes down to lane 0
   assign shifted_dc3 = merged_dc3 >> {dc3.addr[1:0], 3'b000};

   // Sign or zero extension by size
   always_comb begin
      case (dc3.size)
         lsu_pkg::SIZE_BYTE:
            lsu_result = {{(lsu_pkg::XLEN-8){~dc3.unsign & shifted_dc3[7]}},
                          shifted_dc3[7:0]};
         lsu_pkg::SIZE_HALF:
            lsu_result = {{(lsu_pkg::XLEN-16){~dc3.unsign & shifted_dc3[15]}},
                          shifted_dc3[15:0]};
         default:
            lsu_result = shifted_dc3;
      endcase
   end

   // Good load only, errored loads produce nothing
   assign lsu_result_valid = dc3.valid & dc3.load & dc3.in_dccm & ~dc3.misaligned;

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/1ps
// Load/store unit top level
// Three-stage DCCM load/store pipeline with a credit-controlled store
// buffer, error packet, idle and misaligned performance flags

module lsu_top (
   input  logic                     clk,
   input  logic                     rst,
   input  lsu_pkg::lsu_req_t        lsu_req,
   output logic                     lsu_result_valid,
   output logic [lsu_pkg::XLEN-1:0] lsu_result,
   output lsu_pkg::lsu_error_pkt_t  lsu_error_pkt,
   output logic                     lsu_pmu_misaligned,
   output logic                     lsu_idle,
   output lsu_pkg::credit_cnt_t     credit_return
);

   lsu_pkg::lsu_stage_t      dc2;
   lsu_pkg::lsu_stage_t      dc3;
   lsu_pkg::sb_entry_t       drain;          // Oldest buffer entry to DCCM
   logic [lsu_pkg::XLEN-1:0] fwd_data;
   logic [3:0]               fwd_byteen;
   logic                     sb_empty;
   logic                     dc1_valid;      // DC1 occupancy for idle

   always_ff @(posedge clk) begin
      if (rst) dc1_valid <= 1'b0;
      else     dc1_valid <= lsu_req.valid;
   end

   lsu_addr_ctl i_addr_ctl (
      .clk, .rst, .lsu_req, .dc2, .dc3, .lsu_error_pkt
   );

   lsu_stbuf i_stbuf (
      .clk, .rst, .dc3, .drain, .fwd_data, .fwd_byteen, .credit_return, .sb_empty
   );

   lsu_dccm_ctl i_dccm_ctl (
      .clk, .dc2, .dc3, .drain, .fwd_data, .fwd_byteen,
      .lsu_result_valid, .lsu_result
   );

   //******************************
   // Status flags
   assign lsu_pmu_misaligned = dc3.valid & dc3.misaligned;
   assign lsu_idle = ~(dc1_valid | dc2.valid | dc3.valid) & sb_empty;  // Pipe and buffer empty

endmodule

// File: include/lsu_tb_defs.svh
// Load/store unit testbench constants
// Clock, drive timing, wait limits and stimulus table sizing

`ifndef LSU_TB_DEFS_SVH
`define LSU_TB_DEFS_SVH

// Clock and reset
`define LSU_TB_HALF_PERIOD    4        // ns
`define LSU_TB_CLK_PERIOD     8        // ns
`define LSU_TB_RESET_CYCLES   3

// Inputs change this long after the rising edge
`define LSU_TB_DRIVE_DELAY    1        // ns

// Wait limits, in cycles
`define LSU_TB_CREDIT_TIMEOUT 50
`define LSU_TB_IDLE_TIMEOUT   200

// Stimulus table
`define LSU_TB_TABLE_SIZE     48
`define LSU_TB_LCG_SEED       32'h033c11de

`endif

// File: verification/lsu_checker.sv
`timescale 1ns/1ps
// Load/store unit result checker
// Predicts the DUT outputs two cycles after each request from the
// expected error kind and a byte-wide reference memory, counts mismatches
`include "lsu_tb_defs.svh"

module lsu_checker (
   input  logic                     clk,
   input  logic                     rst,
   input  lsu_pkg::lsu_req_t        lsu_req,
   input  logic                     exp_check,     // Table holds a load value
   input  logic [31:0]              exp_value,
   input  logic [1:0]               exp_kind,      // 0 none, 1 misaligned, 2 fault
   input  logic                     lsu_result_valid,
   input  logic [31:0]              lsu_result,
   input  lsu_pkg::lsu_error_pkt_t  lsu_error_pkt,
   input  logic                     lsu_pmu_misaligned,
   output int                       error_count
);

   typedef struct packed {
      logic        valid;
      logic        load;
      logic        store;
      logic [1:0]  kind;
      logic        chk;
      logic [31:0] table_value;
      logic [31:0] pred_value;   // From reference memory
      logic [31:0] addr;
   } expect_t;

   logic [7:0] ref_mem [lsu_pkg::DCCM_BYTES] = '{default: 8'h00};
   expect_t    pipe [3];                        // Slot 2 is the cycle after E2
   expect_t    incoming;
   expect_t    cur;
   int         errors = 0;

   assign error_count = errors;

   function automatic logic [31:0] eff_addr(input lsu_pkg::lsu_req_t r);
      return r.rs1 + {{20{r.offset[11]}}, r.offset};   // Base plus signed offset
   endfunction

   function automatic logic [31:0] read_ref(input logic [31:0] addr,
                                            input lsu_pkg::access_size_e size,
                                            input logic unsign);
      logic [9:0]  idx;
      logic [31:0] w;
      idx = 10'(addr - lsu_pkg::DCCM_BASE);
      w   = {ref_mem[idx+10'd3], ref_mem[idx+10'd2], ref_mem[idx+10'd1], ref_mem[idx]};
      case (size)
         lsu_pkg::SIZE_BYTE: return {{24{~unsign & w[7]}}, w[7:0]};
         lsu_pkg::SIZE_HALF: return {{16{~unsign & w[15]}}, w[15:0]};
         default:            return w;
      endcase
   endfunction

   task automatic write_ref(input logic [31:0] addr, input lsu_pkg::access_size_e size,
                            input logic [31:0] data);
      logic [9:0] idx;
      idx = 10'(addr - lsu_pkg::DCCM_BASE);
      ref_mem[idx] = data[7:0];
      if (size != lsu_pkg::SIZE_BYTE) ref_mem[idx+10'd1] = data[15:8];
      if (size == lsu_pkg::SIZE_WORD) begin
         ref_mem[idx+10'd2] = data[23:16];
         ref_mem[idx+10'd3] = data[31:24];
      end
   endtask

   task automatic compare_word(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
      if (exp_v !== act_v) begin
         $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
         errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
      if (exp_v !== act_v) begin
         $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp_v, act_v);
         errors++;
      end
   endtask

   //******************************
   // Capture requests in program order
   always @(posedge clk) begin
      if (rst) begin
         pipe[0] = '0;
         pipe[1] = '0;
         pipe[2] = '0;
      end else begin
         incoming = '0;
         if (lsu_req.valid) begin
            incoming.valid       = 1'b1;
            incoming.load        = lsu_req.load;
            incoming.store       = lsu_req.store;
            incoming.kind        = exp_kind;
            incoming.chk         = exp_check;
            incoming.table_value = exp_value;
            incoming.addr        = eff_addr(lsu_req);
            if (lsu_req.store && exp_kind == 2'd0)           // Good store updates memory
               write_ref(incoming.addr, lsu_req.size, lsu_req.store_data);
            if (lsu_req.load && exp_kind == 2'd0)
               incoming.pred_value = read_ref(incoming.addr, lsu_req.size, lsu_req.unsign);
         end
         pipe[2] = pipe[1];
         pipe[1] = pipe[0];
         pipe[0] = incoming;
      end
   end

   //******************************
   // Compare mid-cycle, outputs settled
   always @(negedge clk) begin
      if (!rst) begin
         cur = pipe[2];
         compare_bit("lsu_result_valid", cur.valid & cur.load & (cur.kind == 2'd0),
                     lsu_result_valid);
         if (cur.valid && cur.load && cur.kind == 2'd0) begin
            compare_word("lsu_result", cur.pred_value, lsu_result);
            if (cur.chk) compare_word("lsu_result", cur.table_value, lsu_result);
         end
         compare_bit("lsu_error_pkt.valid", cur.valid & (cur.kind != 2'd0),
                     lsu_error_pkt.valid);
         compare_bit("lsu_error_pkt.misaligned", cur.valid & (cur.kind == 2'd1),
                     lsu_error_pkt.misaligned);
         compare_bit("lsu_error_pkt.access_fault", cur.valid & (cur.kind == 2'd2),
                     lsu_error_pkt.access_fault);
         compare_bit("lsu_pmu_misaligned", cur.valid & (cur.kind == 2'd1), lsu_pmu_misaligned);
         if (cur.valid && cur.kind != 2'd0) begin
            compare_word("lsu_error_pkt.addr", cur.addr, lsu_error_pkt.addr);
            compare_bit("lsu_error_pkt.store", cur.store, lsu_error_pkt.store);
         end
      end
   end

endmodule

// File: verification/lsu_tb.sv
`timescale 1ns/1ps
// Load/store unit testbench
// Drives a table of loads, stores and idle waits into the DUT,
// keeps the store credit count and checks the reset state
`include "lsu_tb_defs.svh"

module lsu_tb;

   localparam int          OP_LOAD  = 0;
   localparam int          OP_STORE = 1;
   localparam int          OP_IDLE  = 2;                  // Wait for lsu_idle
   localparam logic [31:0] BASE     = lsu_pkg::DCCM_BASE;

   logic                    clk = 1'b0;
   logic                    rst;
   lsu_pkg::lsu_req_t       lsu_req;
   logic                    exp_check;
   logic [31:0]             exp_value;
   logic [1:0]              exp_kind;
   logic                    lsu_result_valid;
   logic [31:0]             lsu_result;
   lsu_pkg::lsu_error_pkt_t lsu_error_pkt;
   logic                    lsu_pmu_misaligned;
   logic                    lsu_idle;
   lsu_pkg::credit_cnt_t    credit_return;
   int                      chk_errors;
   int                      tb_errors;
   int                      credit_errors = 0;
   int                      credits;                      // Requester side count
   int                      n_entries;
   bit                      aborted;
   bit                      timed_out;
   logic [31:0]             lcg_state;
   logic [31:0]             rand_addr [4];

   // Stimulus table
   int                      t_op     [`LSU_TB_TABLE_SIZE];
   lsu_pkg::access_size_e   t_size   [`LSU_TB_TABLE_SIZE];
   logic                    t_unsign [`LSU_TB_TABLE_SIZE];
   logic [31:0]             t_rs1    [`LSU_TB_TABLE_SIZE];
   logic [11:0]             t_off    [`LSU_TB_TABLE_SIZE];
   logic [31:0]             t_data   [`LSU_TB_TABLE_SIZE];
   logic                    t_chk    [`LSU_TB_TABLE_SIZE];
   logic [31:0]             t_val    [`LSU_TB_TABLE_SIZE];
   logic [1:0]              t_kind   [`LSU_TB_TABLE_SIZE];

   lsu_top i_dut (
      .clk, .rst, .lsu_req, .lsu_result_valid, .lsu_result, .lsu_error_pkt,
      .lsu_pmu_misaligned, .lsu_idle, .credit_return
   );

   lsu_checker i_checker (
      .clk, .rst, .lsu_req, .exp_check, .exp_value, .exp_kind, .lsu_result_valid,
      .lsu_result, .lsu_error_pkt, .lsu_pmu_misaligned, .error_count(chk_errors)
   );

   always #(`LSU_TB_HALF_PERIOD) clk = ~clk;

   // Credits back this cycle, minus the store about to be sampled
   always @(negedge clk) begin
      if (rst) begin
         credits = lsu_pkg::SB_DEPTH;
      end else begin
         credits = credits + int'(credit_return) - ((lsu_req.valid && lsu_req.store) ? 1 : 0);
         if (credits > lsu_pkg::SB_DEPTH || credits < 0) begin
            $display("Credit overflow: count %0d outside 0..%0d at %0t", credits,
                     lsu_pkg::SB_DEPTH, $time);
            credit_errors++;
         end
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic add_entry(input int op, input lsu_pkg::access_size_e size, input logic uns,
                            input logic [31:0] rs1, input logic [11:0] off,
                            input logic [31:0] data, input logic chk, input logic [31:0] val,
                            input logic [1:0] kind);
      t_op[n_entries] = op;
      t_size[n_entries] = size;
      t_unsign[n_entries] = uns;
      t_rs1[n_entries] = rs1;
      t_off[n_entries] = off;
      t_data[n_entries] = data;
      t_chk[n_entries] = chk;
      t_val[n_entries] = val;
      t_kind[n_entries] = kind;
      n_entries++;
   endtask

   //******************************
   task automatic build_table;
      n_entries = 0;
      // Stores, drain, then loads of every size and sign
      add_entry(OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h20, 12'hFF0, 32'h876543A1, 1'b0, 0, 2'd0);
      add_entry(OP_STORE, lsu_pkg::SIZE_HALF, 1'b0, BASE+32'h14, 12'h000, 32'h1234BEEF, 1'b0, 0, 2'd0);
      add_entry(OP_STORE, lsu_pkg::SIZE_BYTE, 1'b0, BASE+32'h10, 12'h007, 32'h0000FF80, 1'b0, 0, 2'd0);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h10, 12'h000, 0, 1'b1, 32'h876543A1, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_HALF, 1'b0, BASE+32'h10, 12'h000, 0, 1'b1, 32'h000043A1, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_HALF, 1'b0, BASE+32'h10, 12'h002, 0, 1'b1, 32'hFFFF8765, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_HALF, 1'b1, BASE+32'h14, 12'hFFE, 0, 1'b1, 32'h00008765, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, BASE+32'h10, 12'h000, 0, 1'b1, 32'hFFFFFFA1, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b1, BASE+32'h10, 12'h000, 0, 1'b1, 32'h000000A1, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, BASE+32'h13, 12'h000, 0, 1'b1, 32'hFFFFFF87, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h14, 12'h000, 0, 1'b1, 32'h8000BEEF, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b1, BASE+32'h17, 12'h000, 0, 1'b1, 32'h00000080, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, BASE+32'h17, 12'h000, 0, 1'b1, 32'hFFFFFF80, 2'd0);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      // Loads right behind stores, bytes still in the buffer
      add_entry(OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h40, 12'h000, 32'h11223344, 1'b0, 0, 2'd0);
      add_entry(OP_STORE, lsu_pkg::SIZE_BYTE, 1'b0, BASE+32'h41, 12'h000, 32'h000000AA, 1'b0, 0, 2'd0);
      add_entry(OP_STORE, lsu_pkg::SIZE_HALF, 1'b0, BASE+32'h42, 12'h000, 32'h00005566, 1'b0, 0, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h40, 12'h000, 0, 1'b1, 32'h5566AA44, 2'd0);
      add_entry(OP_STORE, lsu_pkg::SIZE_BYTE, 1'b0, BASE+32'h40, 12'h000, 32'h00000099, 1'b0, 0, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b1, BASE+32'h40, 12'h000, 0, 1'b1, 32'h00000099, 2'd0);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h40, 12'h000, 0, 1'b1, 32'h5566AA99, 2'd0);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      // Misaligned half and word accesses
      add_entry(OP_STORE, lsu_pkg::SIZE_HALF, 1'b0, BASE+32'h41, 12'h000, 32'h0000DEAD, 1'b0, 0, 2'd1);
      add_entry(OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h42, 12'h000, 32'hCAFEF00D, 1'b0, 0, 2'd1);
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h43, 12'h000, 0, 1'b0, 0, 2'd1);
      add_entry(OP_LOAD, lsu_pkg::SIZE_HALF, 1'b0, BASE+32'h45, 12'h000, 0, 1'b0, 0, 2'd1);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h40, 12'h000, 0, 1'b1, 32'h5566AA99, 2'd0);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      // Outside the DCCM, misalignment still wins
      add_entry(OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h400, 12'h000, 32'hFFFFFFFF, 1'b0, 0, 2'd2);
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE, 12'hFFC, 0, 1'b0, 0, 2'd2);
      add_entry(OP_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, 32'h00001000, 12'h000, 0, 1'b0, 0, 2'd2);
      add_entry(OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, 32'h00000002, 12'h000, 32'h1, 1'b0, 0, 2'd1);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      // Both faulting stores alias word 0, which must still read zero
      add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, BASE+32'h000, 12'h000, 0, 1'b1, 32'h0, 2'd0);
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
      // Burst sized to the credits, random word addresses
      lcg_state = `LSU_TB_LCG_SEED;
      for (int k = 0; k < 4; k++) begin
         lcg_state    = lcg_next(lcg_state);
         rand_addr[k] = BASE + (lcg_state & 32'h0000_03FC);
         lcg_state    = lcg_next(lcg_state);
         add_entry(OP_STORE, lsu_pkg::SIZE_WORD, 1'b0, rand_addr[k], 12'h0, lcg_state, 1'b0, 0, 2'd0);
      end
      for (int k = 0; k < 4; k++) begin
         add_entry(OP_LOAD, lsu_pkg::SIZE_WORD, 1'b0, rand_addr[k], 12'h0, 0, 1'b0, 0, 2'd0);
      end
      add_entry(OP_IDLE, lsu_pkg::SIZE_WORD, 1'b0, 0, 12'h0, 0, 1'b0, 0, 2'd0);
   endtask

   //******************************
   task automatic drive_bubble;
      @(posedge clk);
      #(`LSU_TB_DRIVE_DELAY);
      lsu_req   = '0;
      exp_check = 1'b0;
      exp_value = '0;
      exp_kind  = 2'd0;
   endtask

   task automatic drive_entry(input int i);
      @(posedge clk);
      #(`LSU_TB_DRIVE_DELAY);
      lsu_req.valid      = 1'b1;
      lsu_req.load       = (t_op[i] == OP_LOAD);
      lsu_req.store      = (t_op[i] == OP_STORE);
      lsu_req.size       = t_size[i];
      lsu_req.unsign     = t_unsign[i];
      lsu_req.rs1        = t_rs1[i];
      lsu_req.offset     = t_off[i];
      lsu_req.store_data = t_data[i];
      exp_check          = t_chk[i];
      exp_value          = t_val[i];
      exp_kind           = t_kind[i];
   endtask

   task automatic wait_credit(output bit expired);
      int n;
      int avail;
      n       = 0;
      expired = 1'b0;
      avail   = credits - ((lsu_req.valid && lsu_req.store) ? 1 : 0);  // Store still on the bus
      while (avail <= 0 && !expired) begin
         drive_bubble();
         avail = credits;
         n++;
         if (n >= `LSU_TB_CREDIT_TIMEOUT) expired = 1'b1;
      end
   endtask

   task automatic wait_idle(output bit expired);
      int n;
      n       = 0;
      expired = 1'b0;
      drive_bubble();                                     // Last request enters DC1
      while (!lsu_idle && !expired) begin
         drive_bubble();
         n++;
         if (n >= `LSU_TB_IDLE_TIMEOUT) expired = 1'b1;
      end
   endtask

   task automatic check_reset_state;
      if (lsu_idle !== 1'b1) begin
         $display("[ERROR] %0t lsu_idle expected 1 actual %b", $time, lsu_idle);
         tb_errors++;
      end
      if (lsu_result_valid !== 1'b0) begin
         $display("[ERROR] %0t lsu_result_valid expected 0 actual %b", $time, lsu_result_valid);
         tb_errors++;
      end
      if (lsu_error_pkt.valid !== 1'b0) begin
         $display("[ERROR] %0t lsu_error_pkt.valid expected 0 actual %b", $time,
                  lsu_error_pkt.valid);
         tb_errors++;
      end
      if (lsu_pmu_misaligned !== 1'b0) begin
         $display("[ERROR] %0t lsu_pmu_misaligned expected 0 actual %b", $time,
                  lsu_pmu_misaligned);
         tb_errors++;
      end
      if (credit_return !== 2'd0) begin
         $display("[ERROR] %0t credit_return expected 0 actual %0d", $time, credit_return);
         tb_errors++;
      end
   endtask

   //******************************
   initial begin
      lsu_req   = '0;
      exp_check = 1'b0;
      exp_value = '0;
      exp_kind  = 2'd0;
      rst       = 1'b1;
      tb_errors = 0;
      aborted   = 1'b0;
      build_table();
      repeat (`LSU_TB_RESET_CYCLES) @(posedge clk);
      #(`LSU_TB_DRIVE_DELAY);
      rst = 1'b0;
      check_reset_state();
      for (int i = 0; i < n_entries && !aborted; i++) begin
         if (t_op[i] == OP_IDLE) begin
            wait_idle(timed_out);
            if (timed_out) begin
               $display("Timeout: lsu_idle did not return to 1 after entry %0d", i);
               aborted = 1'b1;
            end else if (credits != lsu_pkg::SB_DEPTH) begin
               $display("Credits returned do not match stores sent: %0d of %0d held",
                        credits, lsu_pkg::SB_DEPTH);
               tb_errors++;
            end
         end else begin
            if (t_op[i] == OP_STORE) begin
               wait_credit(timed_out);
               if (timed_out) begin
                  $display("Timeout: no store credit came back for entry %0d", i);
                  aborted = 1'b1;
               end
            end
            if (!aborted) drive_entry(i);
         end
      end
      drive_bubble();
      repeat (3) @(posedge clk);
      $display("Error counts: checker %0d, testbench %0d, credit %0d", chk_errors, tb_errors,
               credit_errors);
      if (!aborted && chk_errors == 0 && tb_errors == 0 && credit_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+include
hw/lsu_pkg.sv
hw/lsu_addr_ctl.sv
hw/lsu_stbuf.sv
hw/lsu_dccm_ctl.sv
hw/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the load/store unit testbench with Verilator and run it.
# The run fails if the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

echo "Simulation passed"
exit 0
